// File: design/rv_core_pkg.sv
`default_nettype none

package rv_core_pkg;

  localparam int XLEN = 32;

  localparam logic [XLEN-1:0] RESET_PC = '0;

  // Major opcodes in inst[6:2]
  localparam logic [4:0] OPCODE_OP     = 5'b01100;
  localparam logic [4:0] OPCODE_OP_IMM = 5'b00100;
  localparam logic [4:0] OPCODE_LUI    = 5'b01101;
  localparam logic [4:0] OPCODE_AUIPC  = 5'b00101;
  localparam logic [4:0] OPCODE_JAL    = 5'b11011;
  localparam logic [4:0] OPCODE_JALR   = 5'b11001;
  localparam logic [4:0] OPCODE_BRANCH = 5'b11000;

  // ALU operations
  localparam logic [2:0] FUNCT3_ADD  = 3'b000;
  localparam logic [2:0] FUNCT3_SLL  = 3'b001;
  localparam logic [2:0] FUNCT3_SLT  = 3'b010;
  localparam logic [2:0] FUNCT3_SLTU = 3'b011;
  localparam logic [2:0] FUNCT3_XOR  = 3'b100;
  localparam logic [2:0] FUNCT3_SR   = 3'b101;
  localparam logic [2:0] FUNCT3_OR   = 3'b110;
  localparam logic [2:0] FUNCT3_AND  = 3'b111;

  // Branch conditions
  localparam logic [2:0] FUNCT3_BEQ  = 3'b000;
  localparam logic [2:0] FUNCT3_BNE  = 3'b001;
  localparam logic [2:0] FUNCT3_BLT  = 3'b100;
  localparam logic [2:0] FUNCT3_BGE  = 3'b101;
  localparam logic [2:0] FUNCT3_BLTU = 3'b110;
  localparam logic [2:0] FUNCT3_BGEU = 3'b111;

  typedef logic [XLEN-1:0] word_t;
  typedef logic [4:0]      reg_addr_t;

  typedef struct packed {
    word_t pc;
    word_t inst;
  } fetch_t;

  typedef struct packed {
    logic [4:0] opcode;
    logic [2:0] funct3;
    reg_addr_t  rs1_addr;
    reg_addr_t  rs2_addr;
    reg_addr_t  rd_addr;
    logic       rd_wb;
    word_t      imm;
    logic [2:0] alu_op;
    logic       alu_alternate;
    logic       src1_is_pc;
    logic       src1_is_zero;
    logic       src2_is_imm;
  } decoded_t;

  // One retired instruction
  typedef struct packed {
    word_t     pc;
    word_t     inst;
    reg_addr_t rd_addr;
    logic      rd_wb;
    word_t     rd_data;
    word_t     npc;
  } commit_t;

endpackage

`default_nettype wire

// File: design/rv_fetch_port.sv
`timescale 1ns/1ns
`default_nettype none

module rv_fetch_port (
  input  wire                  clk,
  input  wire                  nrst,
  input  wire                  i_fetch_ack,
  input  rv_core_pkg::word_t   i_fetch_inst,
  input  wire                  i_retired,
  input  rv_core_pkg::word_t   i_npc,
  output logic                 o_fetch_req,
  output rv_core_pkg::word_t   o_fetch_pc,
  output rv_core_pkg::fetch_t  o_fetch,
  output logic                 o_issue
);

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_REQ,
    ST_ACK_LOW,
    ST_BUSY
  } state_t;

  state_t             state;
  rv_core_pkg::word_t pc;

  always_ff @(posedge clk) begin
    if (!nrst) begin
      state   <= ST_IDLE;
      pc      <= rv_core_pkg::RESET_PC;
      o_issue <= 1'b0;
    end else begin
      o_issue <= 1'b0;
      case (state)
        ST_IDLE: state <= ST_REQ;
        ST_REQ: begin
          if (i_fetch_ack) begin
            o_issue <= 1'b1;
            state   <= ST_ACK_LOW;
          end
        end
        ST_ACK_LOW: begin
          if (!i_fetch_ack) begin
            state <= ST_BUSY;
          end
        end
        default: begin
          // Wait for the commit side to finish
          if (i_retired) begin
            pc    <= i_npc;
            state <= ST_REQ;
          end
        end
      endcase
    end
  end

  // Capture on the ack edge
  always_ff @(posedge clk) begin
    if (state == ST_REQ && i_fetch_ack) begin
      o_fetch.pc   <= pc;
      o_fetch.inst <= i_fetch_inst;
    end
  end

  assign o_fetch_req = (state == ST_REQ);
  assign o_fetch_pc  = pc;

endmodule

`default_nettype wire

// File: design/rv_decode.sv
`timescale 1ns/1ns
`default_nettype none

module rv_decode (
  input  rv_core_pkg::fetch_t   i_fetch,
  output rv_core_pkg::decoded_t o_decoded
);

  rv_core_pkg::word_t inst;
  logic [4:0]         opcode;
  logic [2:0]         funct3;

  assign inst   = i_fetch.inst;
  assign opcode = inst[6:2];
  assign funct3 = inst[14:12];

  always_comb begin
    o_decoded.opcode   = opcode;
    o_decoded.funct3   = funct3;
    o_decoded.rs1_addr = inst[19:15];
    o_decoded.rs2_addr = inst[24:20];
    o_decoded.rd_addr  = inst[11:7];

    case (opcode)
      rv_core_pkg::OPCODE_LUI, rv_core_pkg::OPCODE_AUIPC:
        o_decoded.imm = {inst[31:12], 12'h000};
      rv_core_pkg::OPCODE_JAL:
        o_decoded.imm = {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};
      rv_core_pkg::OPCODE_BRANCH:
        o_decoded.imm = {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
      default:
        o_decoded.imm = {{20{inst[31]}}, inst[31:20]};
    endcase

    // No writeback for branches or x0
    o_decoded.rd_wb = (inst[11:7] != 5'd0) &&
                      (opcode inside {rv_core_pkg::OPCODE_OP, rv_core_pkg::OPCODE_OP_IMM,
                                      rv_core_pkg::OPCODE_LUI, rv_core_pkg::OPCODE_AUIPC,
                                      rv_core_pkg::OPCODE_JAL, rv_core_pkg::OPCODE_JALR});

    o_decoded.src1_is_zero = (opcode == rv_core_pkg::OPCODE_LUI);
    o_decoded.src1_is_pc   = (opcode == rv_core_pkg::OPCODE_AUIPC) ||
                             (opcode == rv_core_pkg::OPCODE_JAL);
    o_decoded.src2_is_imm  = (opcode != rv_core_pkg::OPCODE_OP) &&
                             (opcode != rv_core_pkg::OPCODE_BRANCH);

    if (opcode == rv_core_pkg::OPCODE_OP || opcode == rv_core_pkg::OPCODE_OP_IMM) begin
      o_decoded.alu_op = funct3;
    end else if (opcode == rv_core_pkg::OPCODE_BRANCH) begin
      case (funct3)
        rv_core_pkg::FUNCT3_BEQ, rv_core_pkg::FUNCT3_BNE:
          o_decoded.alu_op = rv_core_pkg::FUNCT3_XOR;
        rv_core_pkg::FUNCT3_BLT, rv_core_pkg::FUNCT3_BGE:
          o_decoded.alu_op = rv_core_pkg::FUNCT3_SLT;
        default:
          o_decoded.alu_op = rv_core_pkg::FUNCT3_SLTU;
      endcase
    end else begin
      o_decoded.alu_op = rv_core_pkg::FUNCT3_ADD;
    end

    // sub and sra, srai only among the immediates
    if (opcode == rv_core_pkg::OPCODE_OP) begin
      o_decoded.alu_alternate = inst[30];
    end else if (opcode == rv_core_pkg::OPCODE_OP_IMM && funct3 == rv_core_pkg::FUNCT3_SR) begin
      o_decoded.alu_alternate = inst[30];
    end else begin
      o_decoded.alu_alternate = 1'b0;
    end
  end

endmodule

`default_nettype wire

// File: design/rv_regfile.sv
`timescale 1ns/1ns
`default_nettype none

module rv_regfile (
  input  wire                     clk,
  input  wire                     nrst,
  input  rv_core_pkg::reg_addr_t  i_rs1_addr,
  input  rv_core_pkg::reg_addr_t  i_rs2_addr,
  input  wire                     i_we,
  input  rv_core_pkg::reg_addr_t  i_rd_addr,
  input  rv_core_pkg::word_t      i_rd_data,
  output rv_core_pkg::word_t      o_rs1_data,
  output rv_core_pkg::word_t      o_rs2_data
);

  // x1 to x31 only
  rv_core_pkg::word_t regs [1:31];

  always_ff @(posedge clk) begin
    if (!nrst) begin
      regs <= '{default: '0};
    end else if (i_we && i_rd_addr != 5'd0) begin
      regs[i_rd_addr] <= i_rd_data;
    end
  end

  assign o_rs1_data = (i_rs1_addr == 5'd0) ? '0 : regs[i_rs1_addr];
  assign o_rs2_data = (i_rs2_addr == 5'd0) ? '0 : regs[i_rs2_addr];

endmodule

`default_nettype wire

// File: design/rv_execute.sv
`timescale 1ns/1ns
`default_nettype none

module rv_execute (
  input  rv_core_pkg::fetch_t   i_fetch,
  input  rv_core_pkg::decoded_t i_decoded,
  input  rv_core_pkg::word_t    i_rs1_data,
  input  rv_core_pkg::word_t    i_rs2_data,
  output rv_core_pkg::commit_t  o_result
);

  rv_core_pkg::word_t src1;
  rv_core_pkg::word_t src2;
  rv_core_pkg::word_t sra_res;
  rv_core_pkg::word_t alu_res;
  rv_core_pkg::word_t pc_plus4;
  logic               is_jump;
  logic               taken;

  assign src1 = i_decoded.src1_is_zero ? '0 :
                i_decoded.src1_is_pc   ? i_fetch.pc : i_rs1_data;
  assign src2 = i_decoded.src2_is_imm ? i_decoded.imm : i_rs2_data;

  assign sra_res  = $signed(src1) >>> src2[4:0];
  assign pc_plus4 = i_fetch.pc + 32'd4;

  always_comb begin
    alu_res = '0;
    case (i_decoded.alu_op)
      rv_core_pkg::FUNCT3_ADD:  alu_res = i_decoded.alu_alternate ? src1 - src2 : src1 + src2;
      rv_core_pkg::FUNCT3_SLL:  alu_res = src1 << src2[4:0];
      rv_core_pkg::FUNCT3_SLT:  alu_res[0] = $signed(src1) < $signed(src2);
      rv_core_pkg::FUNCT3_SLTU: alu_res[0] = src1 < src2;
      rv_core_pkg::FUNCT3_XOR:  alu_res = src1 ^ src2;
      rv_core_pkg::FUNCT3_SR:   alu_res = i_decoded.alu_alternate ? sra_res : src1 >> src2[4:0];
      rv_core_pkg::FUNCT3_OR:   alu_res = src1 | src2;
      default:                  alu_res = src1 & src2;
    endcase
  end

  assign is_jump = (i_decoded.opcode == rv_core_pkg::OPCODE_JAL) ||
                   (i_decoded.opcode == rv_core_pkg::OPCODE_JALR);

  // Branch compare result lives in alu_res
  always_comb begin
    if (i_decoded.opcode == rv_core_pkg::OPCODE_BRANCH) begin
      if (i_decoded.funct3 inside {rv_core_pkg::FUNCT3_BEQ, rv_core_pkg::FUNCT3_BGE,
                                   rv_core_pkg::FUNCT3_BGEU}) begin
        taken = ~|alu_res;
      end else begin
        taken = |alu_res;
      end
    end else begin
      taken = is_jump;
    end
  end

  always_comb begin
    o_result.pc      = i_fetch.pc;
    o_result.inst    = i_fetch.inst;
    o_result.rd_addr = i_decoded.rd_addr;
    o_result.rd_wb   = i_decoded.rd_wb;
    o_result.rd_data = is_jump ? pc_plus4 : alu_res;
    // rs1 + imm comes out of the ALU for JALR
    if (i_decoded.opcode == rv_core_pkg::OPCODE_JALR) begin
      o_result.npc = {alu_res[rv_core_pkg::XLEN-1:1], 1'b0};
    end else if (taken) begin
      o_result.npc = i_fetch.pc + i_decoded.imm;
    end else begin
      o_result.npc = pc_plus4;
    end
  end

endmodule

`default_nettype wire

// File: design/rv_commit_port.sv
`timescale 1ns/1ns
`default_nettype none

module rv_commit_port (
  input  wire                   clk,
  input  wire                   nrst,
  input  wire                   i_issue,
  input  rv_core_pkg::commit_t  i_result,
  input  wire                   i_commit_ack,
  output logic                  o_commit_req,
  output rv_core_pkg::commit_t  o_commit,
  output logic                  o_we,
  output logic                  o_retired,
  output rv_core_pkg::word_t    o_npc
);

  logic wait_ack_low;

  always_ff @(posedge clk) begin
    if (!nrst) begin
      o_commit_req <= 1'b0;
      wait_ack_low <= 1'b0;
      o_retired    <= 1'b0;
    end else begin
      o_retired <= 1'b0;
      if (i_issue) begin
        o_commit_req <= 1'b1;
      end else if (o_commit_req && i_commit_ack) begin
        o_commit_req <= 1'b0;
        wait_ack_low <= 1'b1;
      end else if (wait_ack_low && !i_commit_ack) begin
        wait_ack_low <= 1'b0;
        o_retired    <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (i_issue) begin
      o_commit <= i_result;
    end
  end

  // Register file write shares the load edge
  assign o_we  = i_issue && i_result.rd_wb;
  assign o_npc = o_commit.npc;

endmodule

`default_nettype wire

// File: design/rv_core_top.sv
`timescale 1ns/1ns
`default_nettype none

module rv_core_top (
  input  wire                   clk,
  input  wire                   nrst,
  input  wire                   i_fetch_ack,
  input  rv_core_pkg::word_t    i_fetch_inst,
  input  wire                   i_commit_ack,
  output logic                  o_fetch_req,
  output rv_core_pkg::word_t    o_fetch_pc,
  output logic                  o_commit_req,
  output rv_core_pkg::commit_t  o_commit
);

  rv_core_pkg::fetch_t   fetch_q;
  rv_core_pkg::decoded_t decoded;
  rv_core_pkg::commit_t  result;
  rv_core_pkg::word_t    rs1_data;
  rv_core_pkg::word_t    rs2_data;
  rv_core_pkg::word_t    npc;
  logic                  issue;
  logic                  we;
  logic                  retired;

  rv_fetch_port u_fetch_port (
    .clk          (clk),
    .nrst         (nrst),
    .i_fetch_ack  (i_fetch_ack),
    .i_fetch_inst (i_fetch_inst),
    .i_retired    (retired),
    .i_npc        (npc),
    .o_fetch_req  (o_fetch_req),
    .o_fetch_pc   (o_fetch_pc),
    .o_fetch      (fetch_q),
    .o_issue      (issue)
  );

  rv_decode u_decode (
    .i_fetch   (fetch_q),
    .o_decoded (decoded)
  );

  rv_regfile u_regfile (
    .clk        (clk),
    .nrst       (nrst),
    .i_rs1_addr (decoded.rs1_addr),
    .i_rs2_addr (decoded.rs2_addr),
    .i_we       (we),
    .i_rd_addr  (result.rd_addr),
    .i_rd_data  (result.rd_data),
    .o_rs1_data (rs1_data),
    .o_rs2_data (rs2_data)
  );

  rv_execute u_execute (
    .i_fetch    (fetch_q),
    .i_decoded  (decoded),
    .i_rs1_data (rs1_data),
    .i_rs2_data (rs2_data),
    .o_result   (result)
  );

  rv_commit_port u_commit_port (
    .clk          (clk),
    .nrst         (nrst),
    .i_issue      (issue),
    .i_result     (result),
    .i_commit_ack (i_commit_ack),
    .o_commit_req (o_commit_req),
    .o_commit     (o_commit),
    .o_we         (we),
    .o_retired    (retired),
    .o_npc        (npc)
  );

endmodule

`default_nettype wire

// File: testbench/tb_rv_core.sv
`timescale 1ns/1ns
`default_nettype none

module tb_rv_core;

  localparam int          NUM_INSTS  = 2000;
  localparam int          WAIT_LIMIT = 64;
  localparam logic [31:0] LFSR_SEED  = 32'h333f_8508;

  logic                 clk;
  logic                 nrst;
  logic                 fetch_ack;
  rv_core_pkg::word_t   fetch_inst;
  logic                 commit_ack;
  logic                 fetch_req;
  rv_core_pkg::word_t   fetch_pc;
  logic                 commit_req;
  rv_core_pkg::commit_t commit;

  logic [31:0]          lfsr_state;
  rv_core_pkg::word_t   model_pc;
  rv_core_pkg::word_t   model_regs [0:31];
  int                   fetch_rises;
  int                   commit_rises;
  logic                 fetch_req_q;
  logic                 commit_req_q;
  rv_core_pkg::commit_t commit_q;

  rv_core_top dut (
    .clk          (clk),
    .nrst         (nrst),
    .i_fetch_ack  (fetch_ack),
    .i_fetch_inst (fetch_inst),
    .i_commit_ack (commit_ack),
    .o_fetch_req  (fetch_req),
    .o_fetch_pc   (fetch_pc),
    .o_commit_req (commit_req),
    .o_commit     (commit)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  function automatic logic [31:0] lfsr_next(input logic [31:0] state);
    return state[0] ? ((state >> 1) ^ 32'h8020_0003) : (state >> 1);
  endfunction

  // One LFSR step per returned bit
  function automatic rv_core_pkg::word_t rand_bits(input int count);
    rv_core_pkg::word_t value;
    int                 i;
    value = '0;
    for (i = 0; i < count; i++) begin
      lfsr_state = lfsr_next(lfsr_state);
      value = {value[30:0], lfsr_state[0]};
    end
    return value;
  endfunction

  task automatic report_failure(input string msg);
    $display("%s", msg);
    $display("ERRORS FOUND");
    $fatal(1, "simulation stopped");
  endtask

  task automatic report_mismatch(input string name, input rv_core_pkg::word_t got,
                                 input rv_core_pkg::word_t exp);
    report_failure($sformatf("[FAIL] %s got %h expected %h", name, got, exp));
  endtask

  task automatic check_word(input string name, input rv_core_pkg::word_t got,
                            input rv_core_pkg::word_t exp);
    if (got !== exp) begin
      report_mismatch(name, got, exp);
    end
  endtask

  task automatic check_commit(input rv_core_pkg::commit_t got, input rv_core_pkg::commit_t exp);
    check_word("o_commit.pc", got.pc, exp.pc);
    check_word("o_commit.inst", got.inst, exp.inst);
    check_word("o_commit.rd_addr", rv_core_pkg::word_t'(got.rd_addr),
               rv_core_pkg::word_t'(exp.rd_addr));
    check_word("o_commit.rd_wb", rv_core_pkg::word_t'(got.rd_wb),
               rv_core_pkg::word_t'(exp.rd_wb));
    check_word("o_commit.rd_data", got.rd_data, exp.rd_data);
    check_word("o_commit.npc", got.npc, exp.npc);
  endtask

  task automatic wait_fetch_req(input logic level);
    int cycles;
    cycles = 0;
    do begin
      @(posedge clk);
      cycles++;
      if (cycles > WAIT_LIMIT) begin
        report_failure($sformatf("Timeout waiting for o_fetch_req to become %0d", level));
      end
    end while (fetch_req !== level);
  endtask

  task automatic wait_commit_req(input logic level);
    int cycles;
    cycles = 0;
    do begin
      @(posedge clk);
      cycles++;
      if (cycles > WAIT_LIMIT) begin
        report_failure($sformatf("Timeout waiting for o_commit_req to become %0d", level));
      end
    end while (commit_req !== level);
  endtask

  function automatic rv_core_pkg::word_t alu_model(input logic [2:0] op, input logic alt,
                                                   input rv_core_pkg::word_t a,
                                                   input rv_core_pkg::word_t b);
    rv_core_pkg::word_t arith;
    arith = $signed(a) >>> b[4:0];
    case (op)
      rv_core_pkg::FUNCT3_ADD:  return alt ? a - b : a + b;
      rv_core_pkg::FUNCT3_SLL:  return a << b[4:0];
      rv_core_pkg::FUNCT3_SLT:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      rv_core_pkg::FUNCT3_SLTU: return (a < b) ? 32'd1 : 32'd0;
      rv_core_pkg::FUNCT3_XOR:  return a ^ b;
      rv_core_pkg::FUNCT3_SR:   return alt ? arith : a >> b[4:0];
      rv_core_pkg::FUNCT3_OR:   return a | b;
      default:                  return a & b;
    endcase
  endfunction

  // Random legal instruction plus its expected commit record
  task automatic make_instruction(output rv_core_pkg::word_t inst,
                                  output rv_core_pkg::commit_t exp);
    logic [2:0]             sel;
    logic [2:0]             f3;
    rv_core_pkg::reg_addr_t rs1;
    rv_core_pkg::reg_addr_t rs2;
    rv_core_pkg::reg_addr_t rd;
    logic [11:0]            imm12;
    logic [19:0]            imm20;
    logic [6:0]             funct7;
    logic                   alt;
    logic                   taken;
    rv_core_pkg::word_t     a;
    rv_core_pkg::word_t     b;
    rv_core_pkg::word_t     imm_val;
    int                     k;
    sel   = 3'(rand_bits(3));
    f3    = 3'(rand_bits(3));
    rs1   = 5'(rand_bits(5));
    rs2   = 5'(rand_bits(5));
    rd    = 5'(rand_bits(5));
    alt   = 1'(rand_bits(1));
    imm12 = 12'(rand_bits(12));
    imm20 = 20'(rand_bits(20));
    a     = model_regs[rs1];
    b     = model_regs[rs2];
    exp.pc      = model_pc;
    exp.rd_addr = rd;
    exp.rd_wb   = (rd != 5'd0);
    exp.npc     = model_pc + 32'd4;
    case (sel)
      3'd0: begin
        funct7 = (alt && (f3 == rv_core_pkg::FUNCT3_ADD || f3 == rv_core_pkg::FUNCT3_SR)) ?
                 7'h20 : 7'h00;
        inst = {funct7, rs2, rs1, f3, rd, rv_core_pkg::OPCODE_OP, 2'b11};
        exp.rd_data = alu_model(f3, funct7[5], a, b);
      end
      3'd1, 3'd2: begin
        if (f3 == rv_core_pkg::FUNCT3_SLL) begin
          imm12[11:5] = 7'h00;
        end else if (f3 == rv_core_pkg::FUNCT3_SR) begin
          imm12[11:5] = alt ? 7'h20 : 7'h00;
        end
        inst = {imm12, rs1, f3, rd, rv_core_pkg::OPCODE_OP_IMM, 2'b11};
        exp.rd_data = alu_model(f3, alt && f3 == rv_core_pkg::FUNCT3_SR, a,
                                {{20{imm12[11]}}, imm12});
      end
      3'd3: begin
        inst = {imm20, rd, rv_core_pkg::OPCODE_LUI, 2'b11};
        exp.rd_data = {imm20, 12'h000};
      end
      3'd4: begin
        inst = {imm20, rd, rv_core_pkg::OPCODE_AUIPC, 2'b11};
        exp.rd_data = model_pc + {imm20, 12'h000};
      end
      3'd5: begin
        imm_val = {{11{imm20[19]}}, imm20, 1'b0};
        inst = {imm20[19], imm20[9:0], imm20[10], imm20[18:11], rd,
                rv_core_pkg::OPCODE_JAL, 2'b11};
        exp.rd_data = model_pc + 32'd4;
        exp.npc     = model_pc + imm_val;
      end
      3'd6: begin
        inst = {imm12, rs1, 3'b000, rd, rv_core_pkg::OPCODE_JALR, 2'b11};
        exp.rd_data = model_pc + 32'd4;
        exp.npc     = (a + {{20{imm12[11]}}, imm12}) & ~32'd1;
      end
      default: begin
        // Indices 0..5 select BEQ BNE BLT BGE BLTU BGEU
        k = int'(rand_bits(3)) % 6;
        f3 = 3'((k < 2) ? k : k + 2);
        imm_val = {{19{imm12[11]}}, imm12, 1'b0};
        inst = {imm12[11], imm12[9:4], rs2, rs1, f3, imm12[3:0], imm12[10],
                rv_core_pkg::OPCODE_BRANCH, 2'b11};
        exp.rd_addr = {imm12[3:0], imm12[10]};
        exp.rd_wb   = 1'b0;
        case (f3)
          rv_core_pkg::FUNCT3_BEQ:  taken = (a == b);
          rv_core_pkg::FUNCT3_BNE:  taken = (a != b);
          rv_core_pkg::FUNCT3_BLT:  taken = ($signed(a) < $signed(b));
          rv_core_pkg::FUNCT3_BGE:  taken = ($signed(a) >= $signed(b));
          rv_core_pkg::FUNCT3_BLTU: taken = (a < b);
          default:                  taken = (a >= b);
        endcase
        if (f3 == rv_core_pkg::FUNCT3_BEQ || f3 == rv_core_pkg::FUNCT3_BNE) begin
          exp.rd_data = alu_model(rv_core_pkg::FUNCT3_XOR, 1'b0, a, b);
        end else if (f3 == rv_core_pkg::FUNCT3_BLT || f3 == rv_core_pkg::FUNCT3_BGE) begin
          exp.rd_data = alu_model(rv_core_pkg::FUNCT3_SLT, 1'b0, a, b);
        end else begin
          exp.rd_data = alu_model(rv_core_pkg::FUNCT3_SLTU, 1'b0, a, b);
        end
        if (taken) begin
          exp.npc = model_pc + imm_val;
        end
      end
    endcase
    exp.inst = inst;
  endtask

  // Handshake rules and fetch/commit pairing
  always @(posedge clk) begin
    if (!nrst) begin
      fetch_req_q  = 1'b0;
      commit_req_q = 1'b0;
    end else begin
      if (fetch_req && !fetch_req_q) begin
        if (fetch_ack) begin
          report_failure("o_fetch_req rose while i_fetch_ack was still high");
        end
        if (commit_req || commit_ack || fetch_rises != commit_rises) begin
          report_failure("Fetch started before the previous commit completed");
        end
        fetch_rises++;
      end
      if (commit_req && !commit_req_q) begin
        if (commit_ack) begin
          report_failure("o_commit_req rose while i_commit_ack was still high");
        end
        if (commit_rises + 1 != fetch_rises) begin
          report_failure("Commit request without a matching fetch");
        end
        commit_rises++;
      end
      if (commit_req && commit_req_q && commit !== commit_q) begin
        report_failure("o_commit changed while o_commit_req was high");
      end
      fetch_req_q  = fetch_req;
      commit_req_q = commit_req;
      commit_q     = commit;
    end
  end

  initial begin : main
    rv_core_pkg::word_t   inst;
    rv_core_pkg::commit_t expected;
    int                   n;
    int                   delay;
    nrst       <= 1'b0;
    fetch_ack  <= 1'b0;
    fetch_inst <= '0;
    commit_ack <= 1'b0;
    lfsr_state   = LFSR_SEED;
    fetch_rises  = 0;
    commit_rises = 0;
    model_pc     = rv_core_pkg::RESET_PC;
    for (n = 0; n < 32; n++) begin
      model_regs[n] = '0;
    end
    repeat (3) @(posedge clk);
    nrst <= 1'b1;

    for (n = 0; n < NUM_INSTS; n++) begin
      wait_fetch_req(1'b1);
      check_word("o_fetch_pc", fetch_pc, model_pc);
      make_instruction(inst, expected);
      delay = int'(rand_bits(2));
      repeat (delay) @(posedge clk);
      fetch_ack  <= 1'b1;
      fetch_inst <= inst;
      wait_fetch_req(1'b0);
      // Ack may linger after req drops
      delay = int'(rand_bits(2));
      repeat (delay) @(posedge clk);
      fetch_ack <= 1'b0;

      wait_commit_req(1'b1);
      check_commit(commit, expected);
      delay = int'(rand_bits(2));
      repeat (delay) @(posedge clk);
      commit_ack <= 1'b1;
      wait_commit_req(1'b0);
      delay = int'(rand_bits(2));
      repeat (delay) @(posedge clk);
      commit_ack <= 1'b0;

      if (expected.rd_wb) begin
        model_regs[expected.rd_addr] = expected.rd_data;
      end
      model_pc = expected.npc;
    end

    @(negedge clk);
    if (commit_rises == NUM_INSTS && fetch_rises == commit_rises) begin
      $display("NO ERRORS");
      $finish;
    end else begin
      $display("Fetch count %0d and commit count %0d do not match %0d instructions",
               fetch_rises, commit_rises, NUM_INSTS);
      $display("ERRORS FOUND");
      $fatal(1, "simulation stopped");
    end
  end

endmodule

`default_nettype wire

// File: rv_core_top.f
design/rv_core_pkg.sv
design/rv_fetch_port.sv
design/rv_decode.sv
design/rv_regfile.sv
design/rv_execute.sv
design/rv_commit_port.sv
design/rv_core_top.sv
testbench/tb_rv_core.sv

// File: Makefile
TOP := tb_rv_core

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build output"

test:
	verilator --binary --timing -j 0 --top-module $(TOP) -f rv_core_top.f
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "NO ERRORS"

clean:
	rm -rf obj_dir
